/* display_tile.f */
+incdir+rtl
rtl/tile_pkg.sv
rtl/vga_timer.sv
rtl/wishbone_manager.sv
rtl/pixel_fetcher.sv
rtl/display_tile.sv
verif/display_tile_assert.sv
verif/display_tile_tb.sv

/* Makefile */
# display tile simulation with verilator

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = display_tile_tb
FILELIST  = display_tile.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/display_tile_tb.sv */
/*
 * display tile testbench
 * wishbone memory model, pixel reference and a comparator that locks
 * onto the sync pins to check pixels, sync widths and the la status
 */
`timescale 1ns/100ps
`include "tile_config.svh"

module display_tile_tb import tile_pkg::*; ();

    // reset, three short frames, two stalled frames, en gap and two more frames
    localparam int TIMEOUT_CYCLES = 5000;
    // well past one 32 pixel window
    localparam logic [5:0] STALL_DELAY = 6'd60;
    localparam int FRAME_PIXELS = `H_VISIBLE * `V_VISIBLE;

    logic          clk;
    logic          reset;
    logic          en;
    logic [127:0]  la_data_in;
    logic [127:0]  la_data_out;
    logic [127:0]  la_oenb;
    logic [33:0]   gpio_in;
    logic [33:0]   gpio_out;
    logic [33:0]   gpio_oeb;
    wb_addr_t      ADR_O;
    pixel_word_t   DAT_O;
    logic [3:0]    SEL_O;
    logic          WE_O;
    logic          STB_O;
    logic          CYC_O;
    pixel_word_t   DAT_I = '0;
    logic          ACK_I = 1'b0;

    // memory model
    pixel_word_t fb_mem [0:`FB_WORDS-1];
    logic [1:0]  ack_delays [0:63];
    logic [5:0]  delay_idx;
    logic [5:0]  wait_left;
    logic        serving;
    logic [2:0]  addr_idx;
    logic        stall;
    integer      seed = 32'h6d46;

    // comparator state
    logic        hs;
    logic        vs;
    logic        pix;
    logic        hs_prev = 1'b1;
    logic        vs_prev = 1'b1;
    logic        cyc_prev = 1'b0;
    logic        en_prev = 1'b1;
    logic        exp_pix;
    logic        in_window;
    logic        seen_underrun = 1'b0;
    logic [15:0] vs_falls = '0;
    int          hcnt = -1;
    int          vline = -1;
    int          hs_low = 0;
    int          vs_low = 0;
    int          pix_checked = 0;
    int          checked_before;
    int          cycles = 0;

    // error counts by check group
    int reset_errs = 0;
    int phase_errs = 0;
    int bus_errs = 0;
    int sync_errs = 0;
    int pixel_errs = 0;
    int status_errs = 0;
    int enable_errs = 0;

    display_tile display_tile_i (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .la_data_in  (la_data_in),
        .la_data_out (la_data_out),
        .la_oenb     (la_oenb),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out),
        .gpio_oeb    (gpio_oeb),
        .ADR_O       (ADR_O),
        .DAT_O       (DAT_O),
        .SEL_O       (SEL_O),
        .WE_O        (WE_O),
        .STB_O       (STB_O),
        .CYC_O       (CYC_O),
        .DAT_I       (DAT_I),
        .ACK_I       (ACK_I)
    );

    bind display_tile display_tile_assert display_tile_assert_i (
        .clk      (clk),
        .reset    (reset),
        .en       (en),
        .ADR_O    (ADR_O),
        .STB_O    (STB_O),
        .CYC_O    (CYC_O),
        .ACK_I    (ACK_I),
        .gpio_oeb (gpio_oeb)
    );

    // frame pixel n is bit n%32 of word n/32 with bit 0 leftmost
    function automatic logic expected_pixel(input int x, input int y);
        logic [7:0] n;
        n = 8'(y * `H_VISIBLE + x);
        return fb_mem[n[7:5]][n[4:0]];
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // wishbone slave acking after a table delay or the stall delay
    always @(posedge clk) begin
        ACK_I <= 1'b0;
        if (reset || !en) begin
            addr_idx <= '0;
        end
        if (reset) begin
            serving   <= 1'b0;
            delay_idx <= '0;
        end else if (CYC_O && STB_O && !ACK_I) begin
            if (!serving) begin
                serving   <= 1'b1;
                delay_idx <= delay_idx + 1'b1;
                wait_left <= stall ? STALL_DELAY : {4'b0, ack_delays[delay_idx]};
                // read cycle with all byte lanes and no write data
                if (WE_O || (SEL_O != 4'hf) || (DAT_O != '0)) begin
                    bus_errs++;
                    $display("ERROR %0t: WE_O %b SEL_O %h DAT_O %h on a read", $time,
                        WE_O, SEL_O, DAT_O);
                end
                // words 0 to 7 in order and wrapping into the next frame
                if (en && !stall) begin
                    if (ADR_O != (wb_addr_t'(`FB_BASE) + {27'b0, addr_idx, 2'b00})) begin
                        bus_errs++;
                        $display("ERROR %0t: ADR_O %h, expected word %0d", $time, ADR_O,
                            addr_idx);
                    end
                    addr_idx <= addr_idx + 1'b1;
                end
            end else if (wait_left == '0) begin
                ACK_I   <= 1'b1;
                DAT_I   <= fb_mem[ADR_O[4:2]];
                serving <= 1'b0;
            end else begin
                wait_left <= wait_left - 1'b1;
            end
        end
    end

    // comparator sampling on the falling edge
    always @(negedge clk) begin
        hs  = gpio_out[`PIN_HSYNC];
        vs  = gpio_out[`PIN_VSYNC];
        pix = gpio_out[`PIN_PIXEL];
        // a cycle may only rise after an edge with en high
        if (CYC_O && !cyc_prev && !en_prev) begin
            enable_errs++;
            $display("ERROR %0t: bus cycle started while en was low", $time);
        end
        cyc_prev = CYC_O;
        en_prev  = en;
        if (reset || !en) begin
            if (!reset && ((gpio_out != '0) || (gpio_oeb != '1))) begin
                enable_errs++;
                $display("ERROR %0t: gpio_out %h gpio_oeb %h with en low", $time,
                    gpio_out, gpio_oeb);
            end
            // relock on fresh sync edges
            hs_prev       = 1'b1;
            vs_prev       = 1'b1;
            hcnt          = -1;
            vline         = -1;
            vs_falls      = '0;
            seen_underrun = 1'b0;
        end else begin
            // only the three tile pins driven, upper la bits stay zero
            if ((gpio_out[33:`PIN_COUNT] != '0) || (la_data_out[127:17] != '0)
                    || (gpio_oeb != {{(34-`PIN_COUNT){1'b1}}, {`PIN_COUNT{1'b0}}})) begin
                enable_errs++;
                $display("ERROR %0t: gpio_out %h gpio_oeb %h la high bits %h with en high",
                    $time, gpio_out, gpio_oeb, la_data_out[127:17]);
            end
            // sync widths
            if (!hs) begin
                hs_low = hs_prev ? 1 : hs_low + 1;
            end else if (!hs_prev && (hs_low != `H_SYNC)) begin
                sync_errs++;
                $display("ERROR %0t: hsync low for %0d cycles", $time, hs_low);
            end
            if (!vs) begin
                vs_low = vs_prev ? 1 : vs_low + 1;
            end else if (!vs_prev && (vs_low != `V_SYNC * `H_TOTAL)) begin
                sync_errs++;
                $display("ERROR %0t: vsync low for %0d cycles", $time, vs_low);
            end
            // position from the sync edges only
            if (hs && !hs_prev) begin
                hcnt = 0;
            end else if (hcnt >= 0) begin
                hcnt++;
            end
            if (vs && !vs_prev) begin
                vline = 0;
            end else if ((vline >= 0) && (hcnt == `H_BACK)) begin
                vline++;
            end
            // one frame counted per vsync
            if (!vs && vs_prev) begin
                vs_falls = vs_falls + 1'b1;
                if (la_data_out[16:1] != vs_falls) begin
                    status_errs++;
                    $display("ERROR %0t: frame_count %0d, expected %0d", $time,
                        la_data_out[16:1], vs_falls);
                end
            end
            // underrun is sticky and absent under short delays
            if (la_data_out[0]) begin
                seen_underrun = 1'b1;
            end else if (seen_underrun) begin
                status_errs++;
                $display("ERROR %0t: underrun cleared while running", $time);
            end
            if (!stall && la_data_out[0]) begin
                status_errs++;
                $display("ERROR %0t: underrun set under short ack delays", $time);
            end
            if ((hcnt >= 0) && (vline >= 0)) begin
                in_window = (hcnt >= `H_BACK) && (hcnt < `H_BACK + `H_VISIBLE)
                    && (vline >= `V_BACK) && (vline < `V_BACK + `V_VISIBLE);
                exp_pix = in_window ? expected_pixel(hcnt - `H_BACK, vline - `V_BACK) : 1'b0;
                if (in_window) begin
                    pix_checked++;
                end
                // a late word may show as blank pixels while stalled
                if ((pix != exp_pix) && !(stall && !pix)) begin
                    pixel_errs++;
                    $display("ERROR %0t: pixel %b at x %0d line %0d, expected %b", $time,
                        pix, hcnt - `H_BACK, vline - `V_BACK, exp_pix);
                end
            end
            hs_prev = hs;
            vs_prev = vs;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        reset      <= 1'b1;
        en         <= 1'b1;
        stall      <= 1'b0;
        la_data_in <= '0;
        la_oenb    <= '1;
        gpio_in    <= '0;
        for (int i = 0; i < `FB_WORDS; i++) begin
            fb_mem[i] = $random(seed);
        end
        for (int i = 0; i < 64; i++) begin
            ack_delays[i] = 2'($unsigned($random(seed)) % 4);
        end
        repeat (15) @(posedge clk);
        // reset values while reset is still high
        @(negedge clk);
        if (CYC_O || STB_O || (la_data_out != '0)) begin
            reset_errs++;
            $display("ERROR %0t: bus or la_data_out active in reset", $time);
        end
        if (!gpio_out[`PIN_HSYNC] || !gpio_out[`PIN_VSYNC] || gpio_out[`PIN_PIXEL]) begin
            reset_errs++;
            $display("ERROR %0t: pins %b in reset, expected syncs high", $time,
                gpio_out[2:0]);
        end
        @(posedge clk);
        reset <= 1'b0;
        // two locked frames with short delays
        wait (vs_falls >= 16'd3);
        @(posedge clk);
        stall <= 1'b1;
        wait (vs_falls >= 16'd5);
        if (!seen_underrun) begin
            phase_errs++;
            $display("underrun was never flagged during the stalled frames");
        end
        @(posedge clk);
        en    <= 1'b0;
        stall <= 1'b0;
        repeat (100) @(posedge clk);
        en <= 1'b1;
        checked_before = pix_checked;
        wait (vs_falls >= 16'd2);
        if (pix_checked - checked_before != FRAME_PIXELS) begin
            phase_errs++;
            $display("first frame after en returned had %0d checked pixels, not %0d",
                pix_checked - checked_before, FRAME_PIXELS);
        end
        $display("errors: reset %0d sync %0d pixel %0d status %0d bus %0d enable %0d phase %0d",
            reset_errs, sync_errs, pixel_errs, status_errs, bus_errs, enable_errs, phase_errs);
        if (reset_errs + sync_errs + pixel_errs + status_errs + bus_errs + enable_errs
                + phase_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verif/display_tile_assert.sv */
/*
 * display tile bus and pin assertions
 * bound onto the tile top
 */
`timescale 1ns/100ps

module display_tile_assert import tile_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        en,
    input wb_addr_t    ADR_O,
    input logic        STB_O,
    input logic        CYC_O,
    input logic        ACK_I,
    input logic [33:0] gpio_oeb
);

    // strobe only inside a cycle
    stb_in_cycle: assert property (@(posedge clk) disable iff (reset) STB_O |-> CYC_O)
        else $error("STB_O high without CYC_O");

    // address held until the slave acks
    adr_held: assert property (@(posedge clk) disable iff (reset)
        (STB_O && !ACK_I) |=> $stable(ADR_O))
        else $error("ADR_O changed during an open bus cycle");

    // disabled tile releases every pin
    pins_released: assert property (@(posedge clk) disable iff (reset)
        !en |-> (gpio_oeb == '1))
        else $error("gpio_oeb not all ones with en low");

endmodule

/* rtl/display_tile.sv */
/*
 * display tile top
 * monochrome scanout from management memory onto three gpio pins,
 * frame status on the logic analyzer
 */
`timescale 1ns/100ps
`include "tile_config.svh"

module display_tile import tile_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          en,
    input  logic [127:0]  la_data_in,
    output logic [127:0]  la_data_out,
    input  logic [127:0]  la_oenb,
    input  logic [33:0]   gpio_in,
    output logic [33:0]   gpio_out,
    output logic [33:0]   gpio_oeb,
    output wb_addr_t      ADR_O,
    output pixel_word_t   DAT_O,
    output logic [3:0]    SEL_O,
    output logic          WE_O,
    output logic          STB_O,
    output logic          CYC_O,
    input  pixel_word_t   DAT_I,
    input  logic          ACK_I
);

    logic         hsync_n;
    logic         vsync_n;
    logic         pixel;
    logic         busy;
    scan_pos_t    scan;
    mem_req_t     mem_req;
    mem_rsp_t     mem_rsp;
    tile_status_t status;

    // timer and fetcher sit in reset while the tile is disabled
    vga_timer timer_i (
        .clk     (clk),
        .reset   (reset),
        .run     (en),
        .hsync_n (hsync_n),
        .vsync_n (vsync_n),
        .scan    (scan)
    );

    pixel_fetcher fetcher_i (
        .clk    (clk),
        .reset  (reset),
        .run    (en),
        .scan   (scan),
        .rsp    (mem_rsp),
        .busy   (busy),
        .req    (mem_req),
        .pixel  (pixel),
        .status (status)
    );

    // not gated by en, an open cycle still completes
    wishbone_manager manager_i (
        .clk   (clk),
        .reset (reset),
        .req   (mem_req),
        .DAT_I (DAT_I),
        .ACK_I (ACK_I),
        .rsp   (mem_rsp),
        .busy  (busy),
        .ADR_O (ADR_O),
        .DAT_O (DAT_O),
        .SEL_O (SEL_O),
        .WE_O  (WE_O),
        .STB_O (STB_O),
        .CYC_O (CYC_O)
    );

    // pins are inputs and low when disabled
    always_comb begin
        la_data_out = '0;
        gpio_out    = '0;
        gpio_oeb    = '1;
        if (en) begin
            gpio_oeb[`PIN_COUNT-1:0] = '0;
            gpio_out[`PIN_HSYNC]     = hsync_n;
            gpio_out[`PIN_VSYNC]     = vsync_n;
            gpio_out[`PIN_PIXEL]     = pixel;
        end
        // frame count above the underrun bit
        la_data_out[$bits(tile_status_t)-1:0] = status;
    end

endmodule

/* rtl/pixel_fetcher.sv */
/*
 * pixel fetcher
 * prefetches framebuffer words, shifts out one pixel per clock,
 * counts frames and flags late words as underrun
 */
`timescale 1ns/100ps
`include "tile_config.svh"

module pixel_fetcher import tile_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         run,
    input  scan_pos_t    scan,
    input  mem_rsp_t     rsp,
    input  logic         busy,
    output mem_req_t     req,
    output logic         pixel,
    output tile_status_t status
);

    localparam word_index_t LAST_WORD = word_index_t'(`FB_WORDS - 1);

    word_index_t fetch_idx;
    pixel_word_t prefetch;
    pixel_word_t shifter;
    logic        prefetch_valid;
    logic [4:0]  bit_cnt;
    logic        armed;
    logic        pending;
    logic        in_flight;
    logic        drop;
    logic        clear;
    logic        load;
    logic        issue;
    logic        accept;

    assign clear  = reset || !run;
    // word boundary inside the visible area
    assign load   = armed && scan.visible && (bit_cnt == '0);
    assign issue  = pending && !busy && run;
    // only the live request may fill the prefetch register
    assign accept = rsp.valid && in_flight && !drop;

    assign req.strobe = issue;
    assign req.addr   = wb_addr_t'(`FB_BASE) + wb_addr_t'({fetch_idx, 2'b00});

    // request tracking
    always_ff @(posedge clk) begin
        if (clear) begin
            fetch_idx <= '0;
            pending   <= 1'b0;
            in_flight <= 1'b0;
            drop      <= 1'b0;
        end else begin
            if (issue) begin
                in_flight <= 1'b1;
            end else if (rsp.valid) begin
                in_flight <= 1'b0;
            end
            if (scan.frame_end || load) begin
                // restart at word 0, or move on even if the word was late
                fetch_idx <= scan.frame_end ? '0 : fetch_idx + 1'b1;
                pending   <= scan.frame_end || (fetch_idx < LAST_WORD);
                // anything still outstanding is now stale
                drop      <= issue || (in_flight && !rsp.valid);
            end else begin
                if (issue) begin
                    pending <= 1'b0;
                end
                if (rsp.valid) begin
                    drop <= 1'b0;
                end
            end
        end
    end

    // prefetch valid, consumed at each load
    always_ff @(posedge clk) begin
        if (clear || scan.frame_end || load) begin
            prefetch_valid <= 1'b0;
        end else if (accept) begin
            prefetch_valid <= 1'b1;
        end
    end

    // word buffers
    always_ff @(posedge clk) begin
        if (accept) begin
            prefetch <= rsp.data;
        end
        if (load) begin
            // missing word shows as blank pixels
            shifter <= prefetch_valid ? (prefetch >> 1) : '0;
        end else if (scan.visible) begin
            shifter <= shifter >> 1;
        end
    end

    // pixel output, frame count and underrun
    always_ff @(posedge clk) begin
        if (clear) begin
            armed   <= 1'b0;
            bit_cnt <= '0;
            pixel   <= 1'b0;
            status  <= '0;
        end else begin
            if (scan.frame_end) begin
                armed              <= 1'b1;
                status.frame_count <= status.frame_count + 1'b1;
            end
            if (load && !prefetch_valid) begin
                status.underrun <= 1'b1;
            end
            // keep the 32 pixel phase tied to the line start
            if (scan.line_end) begin
                bit_cnt <= '0;
            end else if (scan.visible) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (!(armed && scan.visible)) begin
                pixel <= 1'b0;
            end else if (load) begin
                pixel <= prefetch_valid && prefetch[0];
            end else begin
                pixel <= shifter[0];
            end
        end
    end

endmodule

/* rtl/wishbone_manager.sv */
/*
 * wishbone read manager
 * turns a one-cycle read strobe into a classic wishbone read cycle
 */
`timescale 1ns/100ps

module wishbone_manager import tile_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  mem_req_t    req,
    input  pixel_word_t DAT_I,
    input  logic        ACK_I,
    output mem_rsp_t    rsp,
    output logic        busy,
    output wb_addr_t    ADR_O,
    output pixel_word_t DAT_O,
    output logic [3:0]  SEL_O,
    output logic        WE_O,
    output logic        STB_O,
    output logic        CYC_O
);

    bus_state_t  state;
    bus_state_t  state_next;
    wb_addr_t    addr_hold;
    pixel_word_t read_data;

    // bus FSM
    always_comb begin
        state_next = state;
        case (state)
            bus_idle: begin
                if (req.strobe) begin
                    state_next = bus_cycle;
                end
            end
            bus_cycle: begin
                // hold the cycle until the slave acks
                if (ACK_I) begin
                    state_next = bus_done;
                end
            end
            bus_done: begin
                // busy is low here, so a strobe may arrive back to back
                state_next = req.strobe ? bus_cycle : bus_idle;
            end
            default: begin
                state_next = bus_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= bus_idle;
        end else begin
            state <= state_next;
        end
    end

    // address latched with the strobe, stays put for the whole cycle
    always_ff @(posedge clk) begin
        if (req.strobe && (state != bus_cycle)) begin
            addr_hold <= req.addr;
        end
    end

    // read data sampled at ack
    always_ff @(posedge clk) begin
        if ((state == bus_cycle) && ACK_I) begin
            read_data <= DAT_I;
        end
    end

    assign busy  = (state == bus_cycle);
    assign CYC_O = (state == bus_cycle);
    assign STB_O = (state == bus_cycle);
    assign ADR_O = addr_hold;

    // read only master
    assign WE_O  = 1'b0;
    assign SEL_O = 4'hf;
    assign DAT_O = '0;

    // response one cycle after ack
    assign rsp.valid = (state == bus_done);
    assign rsp.data  = read_data;

endmodule

/* rtl/vga_timer.sv */
/*
 * vga timing generator
 * counts pixels and lines, drives registered syncs and scan flags
 */
`timescale 1ns/100ps
`include "tile_config.svh"

module vga_timer import tile_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    output logic      hsync_n,
    output logic      vsync_n,
    output scan_pos_t scan
);

    // sync windows and counter limits
    localparam h_count_t H_LAST   = h_count_t'(`H_TOTAL - 1);
    localparam h_count_t HS_START = h_count_t'(`H_VISIBLE + `H_FRONT);
    localparam h_count_t HS_END   = h_count_t'(`H_VISIBLE + `H_FRONT + `H_SYNC);
    localparam h_count_t H_VIS    = h_count_t'(`H_VISIBLE);
    localparam v_count_t V_LAST   = v_count_t'(`V_TOTAL - 1);
    localparam v_count_t VS_START = v_count_t'(`V_VISIBLE + `V_FRONT);
    localparam v_count_t VS_END   = v_count_t'(`V_VISIBLE + `V_FRONT + `V_SYNC);
    localparam v_count_t V_VIS    = v_count_t'(`V_VISIBLE);

    h_count_t h_count;
    h_count_t h_next;
    v_count_t v_count;
    v_count_t v_next;

    // next scan position, wraps at line and frame end
    always_comb begin
        h_next = h_count + 1'b1;
        v_next = v_count;
        if (h_count == H_LAST) begin
            h_next = '0;
            v_next = (v_count == V_LAST) ? '0 : v_count + 1'b1;
        end
    end

    // syncs come from the current count, scan flags from the next one
    // so the fetcher's pixel register lands on the same edge as the syncs
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            h_count <= '0;
            v_count <= '0;
            hsync_n <= 1'b1;
            vsync_n <= 1'b1;
            scan    <= '0;
        end else begin
            h_count <= h_next;
            v_count <= v_next;
            hsync_n <= !((h_count >= HS_START) && (h_count < HS_END));
            vsync_n <= !((v_count >= VS_START) && (v_count < VS_END));
            scan.visible   <= (h_next < H_VIS) && (v_next < V_VIS);
            scan.line_end  <= (h_next == H_LAST);
            // first blank line, leaves time to prefetch word 0
            scan.frame_end <= (h_next == '0) && (v_next == V_VIS);
        end
    end

endmodule

/* rtl/tile_pkg.sv */
/*
 * display tile types
 * counter widths, bus FSM states and the structs passed between blocks
 */
package tile_pkg;

    // scan counters
    typedef logic [6:0] h_count_t;
    typedef logic [2:0] v_count_t;

    // one framebuffer word, bit 0 is the leftmost pixel
    typedef logic [31:0] pixel_word_t;
    typedef logic [31:0] wb_addr_t;
    typedef logic [7:0]  word_index_t;

    // wishbone manager states
    typedef enum logic [1:0] {
        bus_idle,
        bus_cycle,
        bus_done
    } bus_state_t;

    // position flags for the pixel about to be shown
    typedef struct packed {
        logic visible;
        logic line_end;
        logic frame_end;
    } scan_pos_t;

    // fetcher to manager, single-cycle read strobe
    typedef struct packed {
        logic     strobe;
        wb_addr_t addr;
    } mem_req_t;

    // manager to fetcher, single-cycle read data
    typedef struct packed {
        logic        valid;
        pixel_word_t data;
    } mem_rsp_t;

    // la status word
    typedef struct packed {
        logic [15:0] frame_count;
        logic        underrun;
    } tile_status_t;

endpackage

/* rtl/tile_config.svh */
/*
 * display tile configuration
 * video timing, framebuffer location and gpio pin positions
 */
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// horizontal timing in pixel clocks, visible width a multiple of 32
`define H_VISIBLE 64
`define H_FRONT   4
`define H_SYNC    8
`define H_BACK    4
`define H_TOTAL   (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing in lines
`define V_VISIBLE 4
`define V_FRONT   1
`define V_SYNC    2
`define V_BACK    1
`define V_TOTAL   (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

// framebuffer byte address and its size in 32-bit words
`define FB_BASE   32'h3300_0000
`define FB_WORDS  ((`H_VISIBLE * `V_VISIBLE) / 32)

// gpio bits, the low PIN_COUNT pins are outputs when enabled
`define PIN_HSYNC 0
`define PIN_VSYNC 1
`define PIN_PIXEL 2
`define PIN_COUNT 3

`endif
